//--- hw/cpu_defines.svh
// core width, register file size, reset address and halt opcode macros
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and address width
`define WORD_W 32

// register index width and register count
`define REG_W 5
`define REG_COUNT 32

// fetch address after a start pulse
`define RESET_PC 32'h0000_0000

// opcode that stops the core
`define OP_HALT 6'h3f

`endif

//--- hw/cpu_pkg.sv
// core types: opcode, funct, alu op, branch kind, control state enums and stage structs
`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_W-1:0] regbits_t;

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE  = 6'h00,
		OP_BEQ    = 6'h04,
		OP_BNE    = 6'h05,
		OP_ADDI   = 6'h08,
		OP_ORI    = 6'h0d,
		OP_HALT_E = `OP_HALT
	} opcode_t;

	// r-type function field, instr[5:0]
	typedef enum logic [5:0] {
		F_ADD = 6'h20,
		F_SUB = 6'h22,
		F_AND = 6'h24,
		F_OR  = 6'h25,
		F_SLT = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_t;
	typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_t;
	typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_HALTED} ctrl_state_t;

	typedef struct packed {
		logic valid;
		word_t instr;
		word_t pc_next;
	} if_id_t;

	typedef struct packed {
		logic valid;
		logic wen;
		regbits_t dest;
		alu_op_t alu_op;
		logic alu_src_imm;
		branch_t branch;
		logic halt;
		word_t rdat1;
		word_t rdat2;
		word_t imm_ext;
		word_t pc_next;
	} id_ex_t;

	// no-op that travels down the pipe after a flush
	localparam id_ex_t ID_EX_BUBBLE = '{
		valid: 1'b0, wen: 1'b0, dest: '0, alu_op: ALU_ADD, alu_src_imm: 1'b0,
		branch: BR_NONE, halt: 1'b0, rdat1: '0, rdat2: '0, imm_ext: '0, pc_next: '0
	};

	typedef struct packed {
		logic wen;
		regbits_t dest;
		word_t data;
	} wb_t;

endpackage

//--- hw/fetch_unit.sv
// program counter with clear and branch load, and the IF/ID latch
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_unit (
	input logic CLK,
	input logic nRST,
	input logic run,
	input logic pc_clear,
	input logic flush,
	input logic branch_taken,
	input cpu_pkg::word_t branch_target,
	input cpu_pkg::word_t imem_data,
	output cpu_pkg::word_t imem_addr,
	output cpu_pkg::if_id_t if_id
);
	import cpu_pkg::*;

	word_t pc_q;
	word_t pc_plus4;
	logic valid_q;
	word_t instr_q;
	word_t pc_next_q;

	assign pc_plus4 = pc_q + word_t'(4);
	assign imem_addr = pc_q;

	// clear wins over a branch, a branch wins over sequential flow
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc_q <= `RESET_PC;
		end else if (pc_clear) begin
			pc_q <= `RESET_PC;
		end else if (run) begin
			pc_q <= branch_taken ? branch_target : pc_plus4;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= run && !flush;
		end
	end

	// instruction word and link address, qualified by valid_q
	always_ff @(posedge CLK) begin
		instr_q <= imem_data;
		pc_next_q <= pc_plus4;
	end

	assign if_id = '{valid: valid_q, instr: instr_q, pc_next: pc_next_q};

endmodule

//--- hw/decode_unit.sv
// instruction decoder, register file with forwarding from execute, ID/EX bundle build
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decode_unit (
	input logic CLK,
	input logic nRST,
	input cpu_pkg::if_id_t if_id,
	input cpu_pkg::wb_t wb,
	output cpu_pkg::id_ex_t id_ex_d
);
	import cpu_pkg::*;

	word_t regs [`REG_COUNT];
	opcode_t op;
	funct_t fn;
	regbits_t rs;
	regbits_t rt;
	regbits_t rd;
	logic [15:0] imm;

	assign op = opcode_t'(if_id.instr[31:26]);
	assign fn = funct_t'(if_id.instr[5:0]);
	assign rs = if_id.instr[25:21];
	assign rt = if_id.instr[20:16];
	assign rd = if_id.instr[15:11];
	assign imm = if_id.instr[15:0];

	// r0 is hardwired, a write in flight from execute overrides the array
	function automatic word_t read_reg(input regbits_t idx);
		word_t val;
		if (idx == '0) begin
			val = '0;
		end else if (wb.wen && wb.dest == idx) begin
			val = wb.data;
		end else begin
			val = regs[idx];
		end
		return val;
	endfunction

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.wen) begin
			regs[wb.dest] <= wb.data;
		end
	end

	always_comb begin
		id_ex_d = ID_EX_BUBBLE;
		id_ex_d.rdat1 = read_reg(rs);
		id_ex_d.rdat2 = read_reg(rt);
		id_ex_d.pc_next = if_id.pc_next;
		id_ex_d.imm_ext = {{(`WORD_W-16){imm[15]}}, imm};
		case (op)
			OP_RTYPE: begin
				id_ex_d.valid = 1'b1;
				id_ex_d.wen = 1'b1;
				id_ex_d.dest = rd;
				case (fn)
					F_ADD: id_ex_d.alu_op = ALU_ADD;
					F_SUB: id_ex_d.alu_op = ALU_SUB;
					F_AND: id_ex_d.alu_op = ALU_AND;
					F_OR: id_ex_d.alu_op = ALU_OR;
					F_SLT: id_ex_d.alu_op = ALU_SLT;
					default: begin
						id_ex_d.valid = 1'b0;
						id_ex_d.wen = 1'b0;
					end
				endcase
			end
			OP_ADDI, OP_ORI: begin
				id_ex_d.valid = 1'b1;
				id_ex_d.wen = 1'b1;
				id_ex_d.dest = rt;
				id_ex_d.alu_src_imm = 1'b1;
				if (op == OP_ORI) begin
					// logical immediate is zero extended
					id_ex_d.alu_op = ALU_OR;
					id_ex_d.imm_ext = {{(`WORD_W-16){1'b0}}, imm};
				end
			end
			OP_BEQ: begin
				id_ex_d.valid = 1'b1;
				id_ex_d.branch = BR_EQ;
			end
			OP_BNE: begin
				id_ex_d.valid = 1'b1;
				id_ex_d.branch = BR_NE;
			end
			OP_HALT_E: begin
				id_ex_d.valid = 1'b1;
				id_ex_d.halt = 1'b1;
			end
			default: ;
		endcase
		// slot holds a bubble from fetch
		id_ex_d.valid = id_ex_d.valid && if_id.valid;
	end

	// execute must drop writes aimed at r0
	a_no_r0_write: assert property (@(posedge CLK) disable iff (!nRST)
		wb.wen |-> wb.dest != '0);

endmodule

//--- hw/id_ex_reg.sv
// ID/EX pipeline register with flush to bubble
`timescale 1ns/1ps

module id_ex_reg (
	input logic CLK,
	input logic nRST,
	input logic flush,
	input cpu_pkg::id_ex_t id_ex_d,
	output cpu_pkg::id_ex_t id_ex_q
);
	import cpu_pkg::*;

	id_ex_t q;

	// flush beats the incoming bundle
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			q <= ID_EX_BUBBLE;
		end else if (flush) begin
			q <= ID_EX_BUBBLE;
		end else begin
			q <= id_ex_d;
		end
	end

	assign id_ex_q = q;

	// a flushed slot never reaches execute as a live instruction
	a_flush_bubble: assert property (@(posedge CLK) disable iff (!nRST)
		flush |=> !id_ex_q.valid);

endmodule

//--- hw/execute_unit.sv
// ALU, operand select, branch compare and target, writeback and halt request
`timescale 1ns/1ps

module execute_unit (
	input cpu_pkg::id_ex_t id_ex,
	output cpu_pkg::wb_t wb,
	output logic branch_taken,
	output cpu_pkg::word_t branch_target,
	output logic halt_seen
);
	import cpu_pkg::*;

	word_t opnd_a;
	word_t opnd_b;
	word_t result;
	logic equal;

	assign opnd_a = id_ex.rdat1;
	assign opnd_b = id_ex.alu_src_imm ? id_ex.imm_ext : id_ex.rdat2;

	always_comb begin
		result = '0;
		case (id_ex.alu_op)
			ALU_ADD: result = opnd_a + opnd_b;
			ALU_SUB: result = opnd_a - opnd_b;
			ALU_AND: result = opnd_a & opnd_b;
			ALU_OR: result = opnd_a | opnd_b;
			// signed compare
			ALU_SLT: result[0] = $signed(opnd_a) < $signed(opnd_b);
			default: result = '0;
		endcase
	end

	// r0 writes are dropped here so decode never sees them
	assign wb.wen = id_ex.valid && id_ex.wen && id_ex.dest != '0;
	assign wb.dest = id_ex.dest;
	assign wb.data = result;

	assign equal = id_ex.rdat1 == id_ex.rdat2;
	assign branch_taken = id_ex.valid &&
		((id_ex.branch == BR_EQ && equal) || (id_ex.branch == BR_NE && !equal));

	// word offset relative to pc + 4
	assign branch_target = id_ex.pc_next + {id_ex.imm_ext[$bits(word_t)-3:0], 2'b00};

	assign halt_seen = id_ex.valid && id_ex.halt;

endmodule

//--- hw/pipeline_ctrl.sv
// run-mode FSM for idle, run and halted with pc clear, run enable and flush
`timescale 1ns/1ps

module pipeline_ctrl (
	input logic CLK,
	input logic nRST,
	input logic start,
	input logic branch_taken,
	input logic halt_seen,
	output logic run,
	output logic pc_clear,
	output logic flush,
	output logic halted
);
	import cpu_pkg::*;

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: if (start) state_d = ST_RUN;
			ST_RUN: if (halt_seen) state_d = ST_HALTED;
			ST_HALTED: if (start) state_d = ST_RUN;
			default: state_d = ST_IDLE;
		endcase
	end

	// halt in execute stops fetch at once, so nothing younger gets in
	assign run = state_q == ST_RUN && !halt_seen;
	assign pc_clear = start && state_q != ST_RUN;
	assign flush = (branch_taken && state_q == ST_RUN) || !run;
	assign halted = state_q == ST_HALTED;

	a_run_halt_excl: assert property (@(posedge CLK) disable iff (!nRST)
		!(run && halted));

endmodule

//--- hw/core_top.sv
// three-stage core: fetch, decode, ID/EX register, execute and run control
`timescale 1ns/1ps

module core_top (
	input logic CLK,
	input logic nRST,
	input logic start,
	input cpu_pkg::word_t imem_data,
	output cpu_pkg::word_t imem_addr,
	output cpu_pkg::wb_t wb,
	output logic halted
);
	import cpu_pkg::*;

	logic run;
	logic pc_clear;
	logic flush;
	logic branch_taken;
	logic halt_seen;
	word_t branch_target;
	if_id_t if_id;
	id_ex_t id_ex_d;
	id_ex_t id_ex_q;

	fetch_unit u_fetch (
		.CLK(CLK), .nRST(nRST), .run(run), .pc_clear(pc_clear), .flush(flush),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.imem_data(imem_data), .imem_addr(imem_addr), .if_id(if_id)
	);

	decode_unit u_decode (
		.CLK(CLK), .nRST(nRST), .if_id(if_id), .wb(wb), .id_ex_d(id_ex_d)
	);

	id_ex_reg u_id_ex (
		.CLK(CLK), .nRST(nRST), .flush(flush), .id_ex_d(id_ex_d), .id_ex_q(id_ex_q)
	);

	execute_unit u_execute (
		.id_ex(id_ex_q), .wb(wb), .branch_taken(branch_taken),
		.branch_target(branch_target), .halt_seen(halt_seen)
	);

	pipeline_ctrl u_ctrl (
		.CLK(CLK), .nRST(nRST), .start(start), .branch_taken(branch_taken),
		.halt_seen(halt_seen), .run(run), .pc_clear(pc_clear), .flush(flush),
		.halted(halted)
	);

endmodule

//--- bench/core_tb.sv
// core_top testbench with clock, reset, program ROM, LFSR operands, reference model and assertions
`timescale 1ns/1ps
`include "cpu_defines.svh"

module core_tb;
	import cpu_pkg::*;

	localparam int ROM_WORDS = 64;
	localparam int RAND_WORDS = 10;
	localparam int HALT_LIMIT = 400;

	logic CLK;
	logic nRST;
	logic start;
	logic halted;
	word_t imem_data;
	word_t imem_addr;
	wb_t wb;

	word_t rom [0:ROM_WORDS-1];
	word_t mregs [0:31];
	logic [4:0] exp_dest [0:127];
	word_t exp_data [0:127];
	logic [6:0] exp_count;
	logic [6:0] run1_count;
	logic [6:0] wb_idx;
	logic started;
	wb_t first_wb_run1;
	wb_t first_wb_run2;
	word_t lfsr_state;
	int errors;
	int tests_run;
	int tests_failed;

	core_top dut0 (
		.CLK(CLK), .nRST(nRST), .start(start), .imem_data(imem_data),
		.imem_addr(imem_addr), .wb(wb), .halted(halted)
	);

	// combinational instruction memory
	assign imem_data = rom[imem_addr[7:2]];

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic log_check_failure(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		errors++;
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic word_t lfsr_next(input word_t s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output word_t val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	function automatic word_t encode_itype(opcode_t op, logic [4:0] rt, logic [4:0] rs,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encode_rtype(funct_t fn, logic [4:0] rd, logic [4:0] rs,
			logic [4:0] rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	task automatic build_rom();
		word_t r;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
		logic use_ori;
		// unused words decode as HALT, low bits carry the word index
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom[6'(i)] = {`OP_HALT, 26'(i)};
		end
		// first word reads r0 so both runs start with the same write
		for (int i = 0; i < RAND_WORDS; i++) begin
			draw_bits(3, r);
			rs = (i == 0) ? 5'd0 : {2'b00, r[2:0]};
			draw_bits(3, r);
			rt = (r[2:0] == 3'd0) ? 5'd1 : {2'b00, r[2:0]};
			draw_bits(16, r);
			imm = r[15:0];
			draw_bits(1, r);
			use_ori = r[0];
			rom[6'(i)] = encode_itype(use_ori ? OP_ORI : OP_ADDI, rt, rs, imm);
		end
		rom[10] = encode_itype(OP_ADDI, 5'd0, 5'd1, 16'h0055);
		// dependent chain, each result feeds the next instruction
		rom[11] = encode_rtype(F_ADD, 5'd8, 5'd1, 5'd2);
		rom[12] = encode_rtype(F_SUB, 5'd9, 5'd8, 5'd3);
		rom[13] = encode_rtype(F_AND, 5'd10, 5'd9, 5'd8);
		rom[14] = encode_rtype(F_OR, 5'd11, 5'd10, 5'd4);
		rom[15] = encode_rtype(F_SLT, 5'd12, 5'd9, 5'd5);
		rom[16] = encode_itype(OP_ADDI, 5'd13, 5'd12, 16'hfffd);
		rom[17] = encode_itype(OP_ORI, 5'd14, 5'd13, 16'h8001);
		rom[18] = encode_rtype(F_SLT, 5'd15, 5'd14, 5'd13);
		rom[19] = encode_itype(OP_ADDI, 5'd16, 5'd0, 16'd7);
		rom[20] = encode_itype(OP_ADDI, 5'd17, 5'd0, 16'd7);
		// taken BEQ over 22 and 23, not-taken BNE, taken BNE over 27 and 28
		rom[21] = encode_itype(OP_BEQ, 5'd17, 5'd16, 16'd2);
		rom[22] = encode_itype(OP_ADDI, 5'd18, 5'd0, 16'd1);
		rom[23] = encode_itype(OP_ADDI, 5'd19, 5'd0, 16'd2);
		rom[24] = encode_itype(OP_BNE, 5'd17, 5'd16, 16'd2);
		rom[25] = encode_itype(OP_ADDI, 5'd20, 5'd16, 16'd1);
		rom[26] = encode_itype(OP_BNE, 5'd16, 5'd20, 16'd2);
		rom[27] = encode_itype(OP_ADDI, 5'd21, 5'd0, 16'd3);
		rom[28] = encode_itype(OP_ADDI, 5'd22, 5'd0, 16'd4);
		rom[29] = encode_itype(OP_BEQ, 5'd16, 5'd20, 16'd1);
		rom[30] = encode_rtype(F_SUB, 5'd23, 5'd20, 5'd16);
		rom[31] = {`OP_HALT, 26'd0};
	endtask

	// in-order ISA model, register state carries over between runs
	task automatic run_model();
		word_t pc;
		word_t ins;
		word_t a;
		word_t b;
		word_t res;
		word_t imm_s;
		logic [4:0] dst;
		logic wr;
		logic done;
		int steps;
		pc = `RESET_PC;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 200) begin
			ins = rom[pc[7:2]];
			steps++;
			a = mregs[ins[25:21]];
			b = mregs[ins[20:16]];
			imm_s = {{16{ins[15]}}, ins[15:0]};
			wr = 1'b0;
			dst = ins[20:16];
			res = '0;
			pc = pc + 32'd4;
			case (opcode_t'(ins[31:26]))
				OP_RTYPE: begin
					wr = 1'b1;
					dst = ins[15:11];
					case (funct_t'(ins[5:0]))
						F_ADD: res = a + b;
						F_SUB: res = a - b;
						F_AND: res = a & b;
						F_OR: res = a | b;
						F_SLT: res = {31'b0, $signed(a) < $signed(b)};
						default: wr = 1'b0;
					endcase
				end
				OP_ADDI: begin
					wr = 1'b1;
					res = a + imm_s;
				end
				OP_ORI: begin
					wr = 1'b1;
					res = a | {16'h0000, ins[15:0]};
				end
				OP_BEQ: if (a == b) pc = pc + {imm_s[29:0], 2'b00};
				OP_BNE: if (a != b) pc = pc + {imm_s[29:0], 2'b00};
				default: done = 1'b1;
			endcase
			if (wr && dst != 5'd0) begin
				mregs[dst] = res;
				exp_dest[exp_count] = dst;
				exp_data[exp_count] = res;
				exp_count = exp_count + 7'd1;
			end
		end
	endtask

	// writeback bookkeeping, sampled on the rising edge
	always @(posedge CLK) begin
		if (!nRST) begin
			wb_idx <= '0;
			started <= 1'b0;
		end else begin
			if (start) begin
				started <= 1'b1;
			end
			if (wb.wen) begin
				if (wb_idx == 7'd0) begin
					first_wb_run1 <= wb;
				end
				if (wb_idx == run1_count) begin
					first_wb_run2 <= wb;
				end
				wb_idx <= wb_idx + 7'd1;
			end
		end
	end

	// outputs change on the rising edge, so checks sample on the falling edge
	a_idle_quiet: assert property (@(negedge CLK) disable iff (!nRST)
		!started |-> (!wb.wen && !halted && imem_addr == `RESET_PC))
		else log_check_failure("core not idle before start");

	a_wb_matches_model: assert property (@(negedge CLK) disable iff (!nRST)
		wb.wen |-> (wb_idx < exp_count && wb.dest == exp_dest[wb_idx] &&
			wb.data == exp_data[wb_idx]))
		else log_check_failure($sformatf("wb #%0d got r%0d=%h, expected r%0d=%h",
			wb_idx, wb.dest, wb.data, exp_dest[wb_idx], exp_data[wb_idx]));

	a_no_r0_wb: assert property (@(negedge CLK) disable iff (!nRST)
		wb.wen |-> wb.dest != 5'd0)
		else log_check_failure("writeback to r0");

	// destinations that only the skipped ROM words write
	a_no_skipped_wb: assert property (@(negedge CLK) disable iff (!nRST)
		wb.wen |-> (wb.dest != 5'd18 && wb.dest != 5'd19 && wb.dest != 5'd21 &&
			wb.dest != 5'd22))
		else log_check_failure($sformatf("writeback r%0d from a branch shadow", wb.dest));

	a_halt_no_wb: assert property (@(negedge CLK) disable iff (!nRST)
		halted |-> !wb.wen)
		else log_check_failure("writeback while halted");

	a_halt_addr_frozen: assert property (@(negedge CLK) disable iff (!nRST)
		(halted && $past(halted)) |-> $stable(imem_addr))
		else log_check_failure($sformatf("imem_addr moved to %h while halted", imem_addr));

	task automatic pulse_start();
		start = 1'b1;
		@(negedge CLK);
		start = 1'b0;
	endtask

	task automatic wait_halted(input int limit);
		int n;
		n = 0;
		while (!halted && n < limit) begin
			@(negedge CLK);
			n++;
		end
		if (!halted) begin
			$display("timeout: core did not halt within %0d cycles", limit);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	initial begin
		int mark;
		nRST = 1'b0;
		start = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		lfsr_state = 32'h6f9c0610;
		exp_count = '0;
		for (int i = 0; i < 32; i++) begin
			mregs[5'(i)] = '0;
		end
		build_rom();
		run_model();
		run1_count = exp_count;
		run_model();
		repeat (8) @(negedge CLK);
		nRST = 1'b1;

		mark = errors;
		repeat (6) @(negedge CLK);
		finish_test("reset_idle", mark);

		mark = errors;
		pulse_start();
		wait_halted(HALT_LIMIT);
		assert (wb_idx == run1_count)
			else log_check_failure($sformatf("%0d writebacks in first run, expected %0d",
				wb_idx, run1_count));
		finish_test("program_run", mark);

		mark = errors;
		repeat (6) @(negedge CLK);
		assert (halted) else log_check_failure("halted dropped without start");
		finish_test("halt_hold", mark);

		mark = errors;
		pulse_start();
		wait_halted(HALT_LIMIT);
		assert (wb_idx == exp_count)
			else log_check_failure($sformatf("%0d writebacks after restart, expected %0d",
				wb_idx, exp_count));
		assert (first_wb_run2 == first_wb_run1)
			else log_check_failure("first writeback differs after restart");
		finish_test("restart", mark);

		$display("tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+hw
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/id_ex_reg.sv
hw/execute_unit.sv
hw/pipeline_ctrl.sv
hw/core_top.sv
bench/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module core_tb \
	-o core_tb_sim \
	&& ./obj_dir/core_tb_sim | tee /dev/stderr | grep -q "^Result: PASSED$" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
